//--- source/team_pkg.sv
//------------------------------------------------
// team bus package
// shared widths, word types and loader address
// step for the student-chip bus subsystem
//------------------------------------------------
`default_nettype none

package team_pkg;

    // wishbone widths
    localparam int ADR_W  = 32;
    localparam int DATA_W = 32;
    localparam int SEL_W  = 4;

    typedef logic [ADR_W-1:0]  adr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [SEL_W-1:0]  sel_t;

    // byte distance between consecutive loader words
    localparam int unsigned WORD_STEP = 4;

    // la trigger input and done flag share this bit
    localparam int LA_TRIG_BIT = 32;

endpackage

`default_nettype wire

//--- source/mem_req_if.sv
//------------------------------------------------
// four-phase memory request interface
// requester raises req, completer answers with ack
//------------------------------------------------
`default_nettype none

interface mem_req_if;

    // handshake pair
    logic             req;
    logic             ack;
    // request fields, stable while req is high
    logic             we;
    team_pkg::adr_t   adr;
    team_pkg::data_t  wdata;
    team_pkg::sel_t   sel;
    // read data, valid with ack
    team_pkg::data_t  rdata;

    modport requester (
        output req, we, adr, wdata, sel,
        input  ack, rdata
    );

    modport completer (
        input  req, we, adr, wdata, sel,
        output ack, rdata
    );

endinterface

`default_nettype wire

//--- source/bus_arbiter.sv
//------------------------------------------------
// round-robin arbiter for two four-phase peers
// holds the grant over the whole handshake
//------------------------------------------------
`default_nettype none

module bus_arbiter (
    input  logic         clk,
    input  logic         rst_n,
    mem_req_if.completer req_a,
    mem_req_if.completer req_b,
    mem_req_if.requester mgr
);

    logic busy;
    logic grant_b;
    logic last_b;
    logic pick_b;
    logic granted_req;

    // tie goes to whoever lost last time
    always_comb begin
        if (req_a.req && req_b.req) begin
            pick_b = !last_b;
        end else begin
            pick_b = req_b.req;
        end
    end

    assign granted_req = grant_b ? req_b.req : req_a.req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            grant_b <= 1'b0;
            // loader wins the first tie
            last_b  <= 1'b1;
        end else if (!busy) begin
            if (req_a.req || req_b.req) begin
                busy    <= 1'b1;
                grant_b <= pick_b;
                last_b  <= pick_b;
            end
        end else if (!granted_req && !mgr.ack) begin
            // req and ack both low, handshake finished
            busy <= 1'b0;
        end
    end

    // forward granted fields
    assign mgr.req   = busy && granted_req;
    assign mgr.we    = grant_b ? req_b.we    : req_a.we;
    assign mgr.adr   = grant_b ? req_b.adr   : req_a.adr;
    assign mgr.wdata = grant_b ? req_b.wdata : req_a.wdata;
    assign mgr.sel   = grant_b ? req_b.sel   : req_a.sel;

    // response goes back to the granted port only
    assign req_a.ack   = busy && !grant_b && mgr.ack;
    assign req_b.ack   = busy && grant_b && mgr.ack;
    assign req_a.rdata = (busy && !grant_b) ? mgr.rdata : '0;
    assign req_b.rdata = (busy && grant_b) ? mgr.rdata : '0;

endmodule

`default_nettype wire

//--- source/wishbone_manager.sv
//------------------------------------------------
// wishbone manager
// turns one four-phase request into a single
// classic wishbone cycle toward the mgmt core
//------------------------------------------------
`default_nettype none

module wishbone_manager (
    input  logic            clk,
    input  logic            rst_n,
    input  team_pkg::data_t wb_dat_r,
    input  logic            wb_ack,
    output team_pkg::adr_t  wb_adr,
    output team_pkg::data_t wb_dat_w,
    output team_pkg::sel_t  wb_sel,
    output logic            wb_we,
    output logic            wb_stb,
    output logic            wb_cyc,
    mem_req_if.completer    bus
);

    typedef enum logic [1:0] {
        IDLE,
        CYCLE,
        RESPOND
    } state_t;

    state_t          state;
    logic            ack_q;
    team_pkg::data_t rdata_q;
    logic            start;
    logic            finish;

    // new request seen while idle
    assign start  = (state == IDLE) && bus.req && !ack_q;
    // slave answered this cycle
    assign finish = (state == CYCLE) && wb_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= IDLE;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            ack_q  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= bus.we;
                        state  <= CYCLE;
                    end
                end
                CYCLE: begin
                    if (finish) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        ack_q  <= 1'b1;
                        state  <= RESPOND;
                    end
                end
                RESPOND: begin
                    // wait for the requester to let go
                    if (!bus.req) begin
                        ack_q <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // address, data and read capture
    always_ff @(posedge clk) begin
        if (start) begin
            wb_adr   <= bus.adr;
            wb_dat_w <= bus.wdata;
            wb_sel   <= bus.sel;
        end
        if (finish) begin
            rdata_q <= wb_dat_r;
        end
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

//--- source/uart_rx_loader.sv
//------------------------------------------------
// uart loader
// receives 8N1 bytes, packs four per word and
// writes words to consecutive bus addresses
//------------------------------------------------
`default_nettype none

module uart_rx_loader #(
    parameter int             CLKS_PER_BIT = 16,
    parameter team_pkg::adr_t LOAD_BASE    = 32'h3000_0000
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         en,
    input  logic         rx,
    output logic         error,
    mem_req_if.requester bus
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);
    localparam team_pkg::adr_t STEP = team_pkg::adr_t'(team_pkg::WORD_STEP);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

    state_t          state;
    logic            rx_meta;
    logic            rx_sync;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]      bit_idx;
    logic [1:0]      byte_idx;
    logic [7:0]      shift;
    logic [23:0]     word_buf;
    logic            req_q;
    team_pkg::adr_t  adr_q;
    team_pkg::adr_t  next_adr;
    team_pkg::data_t wdata_q;
    logic            bit_tick;
    logic            shift_en;
    logic            byte_done;
    logic            word_done;
    logic            word_go;

    assign bit_tick  = (clk_cnt == FULL);
    assign shift_en  = en && (state == DATA) && bit_tick;
    // stop bit high, byte accepted
    assign byte_done = en && (state == STOP) && bit_tick && rx_sync;
    assign word_done = byte_done && (byte_idx == 2'd3);
    // previous write still open means overrun
    assign word_go   = word_done && !req_q && !bus.ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta  <= 1'b1;
            rx_sync  <= 1'b1;
            state    <= IDLE;
            clk_cnt  <= '0;
            bit_idx  <= 3'd0;
            byte_idx <= 2'd0;
            req_q    <= 1'b0;
            error    <= 1'b0;
            next_adr <= LOAD_BASE;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            // close handshake even while disabled
            if (req_q && bus.ack) begin
                req_q <= 1'b0;
            end
            if (!en) begin
                state    <= IDLE;
                clk_cnt  <= '0;
                byte_idx <= 2'd0;
            end else begin
                case (state)
                    IDLE: begin
                        clk_cnt <= '0;
                        if (!rx_sync) begin
                            state <= START;
                        end
                    end
                    START: begin
                        // recheck start at mid bit
                        if (clk_cnt == HALF) begin
                            clk_cnt <= '0;
                            bit_idx <= 3'd0;
                            state   <= rx_sync ? IDLE : DATA;
                        end else begin
                            clk_cnt <= clk_cnt + 1'b1;
                        end
                    end
                    DATA: begin
                        if (bit_tick) begin
                            clk_cnt <= '0;
                            bit_idx <= bit_idx + 3'd1;
                            if (bit_idx == 3'd7) begin
                                state <= STOP;
                            end
                        end else begin
                            clk_cnt <= clk_cnt + 1'b1;
                        end
                    end
                    STOP: begin
                        if (bit_tick) begin
                            clk_cnt <= '0;
                            state   <= IDLE;
                            if (!rx_sync) begin
                                // framing error drops the partial word
                                error    <= 1'b1;
                                byte_idx <= 2'd0;
                            end else begin
                                byte_idx <= byte_idx + 2'd1;
                            end
                            if (word_done && !word_go) begin
                                error <= 1'b1;
                            end
                            if (word_go) begin
                                req_q    <= 1'b1;
                                next_adr <= next_adr + STEP;
                            end
                        end else begin
                            clk_cnt <= clk_cnt + 1'b1;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // lsb first shift, byte packing and write fields
    always_ff @(posedge clk) begin
        if (shift_en) begin
            shift <= {rx_sync, shift[7:1]};
        end
        if (byte_done && (byte_idx != 2'd3)) begin
            word_buf[{byte_idx, 3'b000} +: 8] <= shift;
        end
        if (word_go) begin
            wdata_q <= {shift, word_buf};
            adr_q   <= next_adr;
        end
    end

    assign bus.req   = req_q;
    assign bus.we    = 1'b1;
    assign bus.adr   = adr_q;
    assign bus.wdata = wdata_q;
    assign bus.sel   = '1;

endmodule

`default_nettype wire

//--- source/la_debug_reader.sv
//------------------------------------------------
// logic-analyzer debug reader
// one bus read per trigger edge, result on la out
//------------------------------------------------
`default_nettype none

module la_debug_reader (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          en,
    input  logic [127:0]  la_data_in,
    input  logic [127:0]  la_oenb,
    output logic [127:0]  la_data_out,
    mem_req_if.requester  bus
);

    logic            trig_in;
    logic            trig_q;
    logic            trig_rise;
    logic            req_q;
    logic            done;
    team_pkg::adr_t  adr_q;
    team_pkg::data_t rdata_q;
    logic            launch;

    // trigger only counts when the pin is driven by the host
    assign trig_in   = la_data_in[team_pkg::LA_TRIG_BIT] &&
                       !la_oenb[team_pkg::LA_TRIG_BIT] && en;
    assign trig_rise = trig_in && !trig_q;
    assign launch    = trig_rise && !req_q && !bus.ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            trig_q  <= 1'b0;
            req_q   <= 1'b0;
            done    <= 1'b0;
            rdata_q <= '0;
        end else begin
            trig_q <= trig_in;
            if (launch) begin
                req_q <= 1'b1;
            end
            if (req_q && bus.ack) begin
                req_q   <= 1'b0;
                rdata_q <= bus.rdata;
                done    <= 1'b1;
            end else if (!trig_in) begin
                done <= 1'b0;
            end
        end
    end

    // address captured at the trigger edge
    always_ff @(posedge clk) begin
        if (launch) begin
            adr_q <= la_data_in[team_pkg::ADR_W-1:0];
        end
    end

    always_comb begin
        la_data_out = '0;
        la_data_out[team_pkg::DATA_W-1:0] = rdata_q;
        la_data_out[team_pkg::LA_TRIG_BIT] = done;
    end

    // read only, full word
    assign bus.req   = req_q;
    assign bus.we    = 1'b0;
    assign bus.adr   = adr_q;
    assign bus.wdata = '0;
    assign bus.sel   = '1;

endmodule

`default_nettype wire

//--- source/team_04.sv
//------------------------------------------------
// team 04 integration top
// uart loader and la reader share one wishbone
// manager port through a round-robin arbiter
//------------------------------------------------
`default_nettype none

module team_04 #(
    parameter int             CLKS_PER_BIT = 16,
    parameter team_pkg::adr_t LOAD_BASE    = 32'h3000_0000
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    // logic analyzer
    input  logic [127:0]    la_data_in,
    output logic [127:0]    la_data_out,
    input  logic [127:0]    la_oenb,
    // breakout gpio, oeb active low
    input  logic [33:0]     gpio_in,
    output logic [33:0]     gpio_out,
    output logic [33:0]     gpio_oeb,
    // wishbone to the management core
    output team_pkg::adr_t  wb_adr,
    output team_pkg::data_t wb_dat_w,
    output team_pkg::sel_t  wb_sel,
    output logic            wb_we,
    output logic            wb_stb,
    output logic            wb_cyc,
    input  team_pkg::data_t wb_dat_r,
    input  logic            wb_ack
);

    mem_req_if loader_bus ();
    mem_req_if reader_bus ();
    mem_req_if mgr_bus ();

    logic loader_error;

    // rx on gpio 5
    uart_rx_loader #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .LOAD_BASE    (LOAD_BASE)
    ) u_loader (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .rx    (gpio_in[5]),
        .error (loader_error),
        .bus   (loader_bus.requester)
    );

    la_debug_reader u_reader (
        .clk         (clk),
        .rst_n       (rst_n),
        .en          (en),
        .la_data_in  (la_data_in),
        .la_oenb     (la_oenb),
        .la_data_out (la_data_out),
        .bus         (reader_bus.requester)
    );

    // loader on port a, preferred after reset
    bus_arbiter u_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .req_a (loader_bus.completer),
        .req_b (reader_bus.completer),
        .mgr   (mgr_bus.requester)
    );

    wishbone_manager u_wb_mgr (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_sel   (wb_sel),
        .wb_we    (wb_we),
        .wb_stb   (wb_stb),
        .wb_cyc   (wb_cyc),
        .bus      (mgr_bus.completer)
    );

    // gpio drive only while enabled
    always_comb begin
        gpio_out = '0;
        gpio_oeb = '1;
        if (en) begin
            gpio_oeb[1:0] = 2'b00;
            // bus busy light
            gpio_out[0] = wb_cyc;
            gpio_out[1] = loader_error;
        end
    end

endmodule

`default_nettype wire

//--- verif/wb_mem_model.sv
//------------------------------------------------
// wishbone slave memory model
// 256 words, acks after a set delay, backdoor
//------------------------------------------------
`default_nettype none

module wb_mem_model (
    input  logic            clk,
    input  logic            rst_n,
    input  team_pkg::adr_t  wb_adr,
    input  team_pkg::data_t wb_dat_w,
    input  team_pkg::sel_t  wb_sel,
    input  logic            wb_we,
    input  logic            wb_stb,
    input  logic            wb_cyc,
    output team_pkg::data_t wb_dat_r,
    output logic            wb_ack,
    // wait states before ack, 0 to 3
    input  logic [1:0]      delay,
    // backdoor write port
    input  logic            bd_we,
    input  logic [7:0]      bd_idx,
    input  team_pkg::data_t bd_data,
    output int unsigned     write_count
);
    timeunit 1ns;
    timeprecision 1ps;

    team_pkg::data_t words [256];
    logic [1:0]      wait_cnt;
    logic [7:0]      idx;

    // word index from byte address
    assign idx = wb_adr[9:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_ack      <= 1'b0;
            wb_dat_r    <= '0;
            wait_cnt    <= 2'd0;
            write_count <= 0;
        end else if (wb_ack) begin
            // single cycle ack
            wb_ack   <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (wb_cyc && wb_stb) begin
            if (wait_cnt == delay) begin
                wb_ack <= 1'b1;
                if (wb_we) begin
                    // only selected byte lanes are written
                    for (int k = 0; k < team_pkg::SEL_W; k++) begin
                        if (wb_sel[k]) begin
                            words[idx][8*k +: 8] <= wb_dat_w[8*k +: 8];
                        end
                    end
                    write_count <= write_count + 1;
                end else begin
                    wb_dat_r <= words[idx];
                end
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end
        if (bd_we) begin
            words[bd_idx] <= bd_data;
        end
    end

endmodule

`default_nettype wire

//--- verif/team_04_assert.sv
//------------------------------------------------
// team_04 protocol assertions
// wishbone strobe, four-phase handshake, grants
//------------------------------------------------
`default_nettype none

module team_04_assert (
    input logic            clk,
    input logic            rst_n,
    input logic            wb_cyc,
    input logic            wb_stb,
    input logic            mgr_req,
    input logic            mgr_ack,
    input logic            mgr_we,
    input team_pkg::adr_t  mgr_adr,
    input team_pkg::data_t mgr_wdata,
    input team_pkg::sel_t  mgr_sel,
    input logic            loader_ack,
    input logic            reader_ack
);
    timeunit 1ns;
    timeprecision 1ps;

    // read by the testbench watcher
    int failures = 0;

    stb_inside_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb |-> wb_cyc)
        else begin
            failures++;
            $error("wb_stb high outside a wishbone cycle");
        end

    // request fields frozen until the completer answers
    fields_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mgr_req && !mgr_ack) |=> $stable({mgr_we, mgr_adr, mgr_wdata, mgr_sel}))
        else begin
            failures++;
            $error("mgr_bus fields changed while waiting for ack");
        end

    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mgr_ack) |-> mgr_req)
        else begin
            failures++;
            $error("mgr_bus ack rose without a pending req");
        end

    one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(loader_ack && reader_ack))
        else begin
            failures++;
            $error("arbiter acknowledged both peers at once");
        end

endmodule

bind team_04 team_04_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .mgr_req    (mgr_bus.req),
    .mgr_ack    (mgr_bus.ack),
    .mgr_we     (mgr_bus.we),
    .mgr_adr    (mgr_bus.adr),
    .mgr_wdata  (mgr_bus.wdata),
    .mgr_sel    (mgr_bus.sel),
    .loader_ack (loader_bus.ack),
    .reader_ack (reader_bus.ack)
);

`default_nettype wire

//--- verif/tb_team_04.sv
//------------------------------------------------
// team_04 testbench
// directed tests for uart loader, la reader,
// arbitration, framing error and enable gating
//------------------------------------------------
`default_nettype none

module tb_team_04;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int             CLKS_PER_BIT = 16;
    localparam team_pkg::adr_t LOAD_BASE    = 32'h3000_0000;
    // 21 uart bytes at 160 clocks plus reads is under 4000, wide margin
    localparam int             TIMEOUT_CYCLES = 20000;

    logic            clk;
    logic            rst_n;
    logic            en;
    logic [127:0]    la_data_in;
    logic [127:0]    la_oenb;
    logic [127:0]    la_data_out;
    logic [33:0]     gpio_in;
    logic [33:0]     gpio_out;
    logic [33:0]     gpio_oeb;
    team_pkg::adr_t  wb_adr;
    team_pkg::data_t wb_dat_w;
    team_pkg::sel_t  wb_sel;
    logic            wb_we;
    logic            wb_stb;
    logic            wb_cyc;
    team_pkg::data_t wb_dat_r;
    logic            wb_ack;
    logic [1:0]      mem_delay;
    logic            bd_we;
    logic [7:0]      bd_idx;
    team_pkg::data_t bd_data;
    int unsigned     mem_write_count;
    logic [15:0]     lfsr_state = 16'd34926;
    int              cycles = 0;

    team_04 #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .LOAD_BASE    (LOAD_BASE)
    ) uut (
        .clk (clk), .rst_n (rst_n), .en (en),
        .la_data_in (la_data_in), .la_data_out (la_data_out), .la_oenb (la_oenb),
        .gpio_in (gpio_in), .gpio_out (gpio_out), .gpio_oeb (gpio_oeb),
        .wb_adr (wb_adr), .wb_dat_w (wb_dat_w), .wb_sel (wb_sel), .wb_we (wb_we),
        .wb_stb (wb_stb), .wb_cyc (wb_cyc), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack)
    );

    wb_mem_model mem (
        .clk (clk), .rst_n (rst_n),
        .wb_adr (wb_adr), .wb_dat_w (wb_dat_w), .wb_sel (wb_sel), .wb_we (wb_we),
        .wb_stb (wb_stb), .wb_cyc (wb_cyc), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .delay (mem_delay), .bd_we (bd_we), .bd_idx (bd_idx), .bd_data (bd_data),
        .write_count (mem_write_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // watchdog and assertion monitor
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "run stopped by the watchdog");
        end else if (uut.u_assert.failures != 0) begin
            $display("a protocol assertion failed at %0t ns", $time);
            $display("Simulation failed");
            $fatal(1, "run stopped on an assertion");
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < nbits; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            bits = {bits[30:0], fb};
        end
        return bits;
    endfunction

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %0h got %0h", $time, name,
                     expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // 8N1 frame, lsb first, called on a falling edge
    task automatic uart_send_byte(input logic [7:0] data, input logic stop_bit);
        gpio_in[5] = 1'b0;
        repeat (CLKS_PER_BIT) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            gpio_in[5] = data[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        gpio_in[5] = stop_bit;
        repeat (CLKS_PER_BIT) @(negedge clk);
        // bad stop leaves the line low, idle one bit
        if (!stop_bit) begin
            gpio_in[5] = 1'b1;
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    // trigger edge, wait for done, drop trigger, done must clear
    task automatic la_read(input team_pkg::adr_t addr, output team_pkg::data_t data);
        la_data_in[31:0] = addr;
        la_data_in[team_pkg::LA_TRIG_BIT] = 1'b1;
        while (la_data_out[team_pkg::LA_TRIG_BIT] !== 1'b1) begin
            @(negedge clk);
            // busy light follows the wishbone cycle
            check("gpio_out[0]", 128'(wb_cyc), 128'(gpio_out[0]));
        end
        data = la_data_out[31:0];
        la_data_in[team_pkg::LA_TRIG_BIT] = 1'b0;
        @(negedge clk);
        check("la done flag after trigger drop", 128'(0),
              128'(la_data_out[team_pkg::LA_TRIG_BIT]));
    endtask

    task automatic mem_preload(input logic [7:0] idx, input team_pkg::data_t value);
        bd_idx  = idx;
        bd_data = value;
        bd_we   = 1'b1;
        @(negedge clk);
        bd_we   = 1'b0;
    endtask

    task automatic wait_writes(input int unsigned count);
        while (mem_write_count < count) begin
            @(negedge clk);
        end
        check("memory write count", 128'(count), 128'(mem_write_count));
    endtask

    task automatic reset_state_test();
        check("wb_cyc", 128'(0), 128'(wb_cyc));
        check("wb_stb", 128'(0), 128'(wb_stb));
        check("la_data_out", 128'(0), la_data_out);
        check("gpio_out", 128'(0), 128'(gpio_out));
        check("gpio_oeb", 128'(34'h3_FFFF_FFFF), 128'(gpio_oeb));
    endtask

    task automatic loader_write_test();
        logic [7:0] b [8];
        mem_delay = 2'(lfsr_take(2));
        for (int i = 0; i < 8; i++) begin
            b[i] = 8'(lfsr_take(8));
        end
        for (int i = 0; i < 8; i++) begin
            uart_send_byte(b[i], 1'b1);
        end
        wait_writes(2);
        // first byte lands in bits 7:0
        check("mem.words[0]", 128'({b[3], b[2], b[1], b[0]}), 128'(mem.words[0]));
        check("mem.words[1]", 128'({b[7], b[6], b[5], b[4]}), 128'(mem.words[1]));
        check("gpio_out[1]", 128'(0), 128'(gpio_out[1]));
    endtask

    task automatic debug_read_test();
        team_pkg::data_t word;
        team_pkg::data_t rd;
        mem_delay = 2'(lfsr_take(2));
        word = lfsr_take(32);
        mem_preload(8'h40, word);
        la_read(32'h0000_0100, rd);
        check("la_data_out[31:0]", 128'(word), 128'(rd));
    endtask

    task automatic contention_test();
        logic [7:0]      b [4];
        team_pkg::data_t word;
        team_pkg::data_t rd;
        mem_delay = 2'(lfsr_take(2));
        word = lfsr_take(32);
        for (int i = 0; i < 4; i++) begin
            b[i] = 8'(lfsr_take(8));
        end
        mem_preload(8'h41, word);
        for (int i = 0; i < 3; i++) begin
            uart_send_byte(b[i], 1'b1);
        end
        // trigger lands on the stop sample of the last byte
        fork
            uart_send_byte(b[3], 1'b1);
            begin
                repeat (154) @(negedge clk);
                la_read(32'h0000_0104, rd);
            end
        join
        check("la_data_out[31:0] under contention", 128'(word), 128'(rd));
        wait_writes(3);
        check("mem.words[2]", 128'({b[3], b[2], b[1], b[0]}), 128'(mem.words[2]));
    endtask

    task automatic framing_error_test();
        logic [7:0] b [4];
        for (int i = 0; i < 4; i++) begin
            b[i] = 8'(lfsr_take(8));
        end
        uart_send_byte(8'(lfsr_take(8)), 1'b0);
        check("gpio_out[1] after framing error", 128'(1), 128'(gpio_out[1]));
        check("write count after framing error", 128'(3), 128'(mem_write_count));
        for (int i = 0; i < 4; i++) begin
            uart_send_byte(b[i], 1'b1);
        end
        wait_writes(4);
        check("mem.words[3]", 128'({b[3], b[2], b[1], b[0]}), 128'(mem.words[3]));
    endtask

    task automatic enable_test();
        team_pkg::data_t word;
        team_pkg::data_t rd;
        word = lfsr_take(32);
        mem_preload(8'h42, word);
        en = 1'b0;
        @(negedge clk);
        check("gpio_out while disabled", 128'(0), 128'(gpio_out));
        check("gpio_oeb while disabled", 128'(34'h3_FFFF_FFFF), 128'(gpio_oeb));
        for (int i = 0; i < 4; i++) begin
            uart_send_byte(8'(lfsr_take(8)), 1'b1);
        end
        la_data_in[31:0] = 32'h0000_0108;
        la_data_in[team_pkg::LA_TRIG_BIT] = 1'b1;
        repeat (10) @(negedge clk);
        check("la done flag while disabled", 128'(0),
              128'(la_data_out[team_pkg::LA_TRIG_BIT]));
        // late enough for any slow write to have landed
        check("write count while disabled", 128'(4), 128'(mem_write_count));
        la_data_in[team_pkg::LA_TRIG_BIT] = 1'b0;
        @(negedge clk);
        en = 1'b1;
        @(negedge clk);
        check("gpio_oeb when enabled", 128'(34'h3_FFFF_FFFC), 128'(gpio_oeb));
        la_read(32'h0000_0108, rd);
        check("la_data_out[31:0] after enable", 128'(word), 128'(rd));
    endtask

    initial begin
        rst_n      = 1'b0;
        en         = 1'b0;
        la_data_in = '0;
        la_oenb    = '0;
        // uart line idles high
        gpio_in    = 34'h0_0000_0020;
        mem_delay  = 2'd0;
        bd_we      = 1'b0;
        bd_idx     = 8'd0;
        bd_data    = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        reset_state_test();
        en = 1'b1;
        @(negedge clk);
        loader_write_test();
        debug_read_test();
        contention_test();
        framing_error_test();
        enable_test();
        repeat (4) @(negedge clk);
        if (uut.u_assert.failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/team_pkg.sv
source/mem_req_if.sv
source/bus_arbiter.sv
source/wishbone_manager.sv
source/uart_rx_loader.sv
source/la_debug_reader.sv
source/team_04.sv
verif/wb_mem_model.sv
verif/team_04_assert.sv
verif/tb_team_04.sv

//--- Makefile
# verilator simulation of the team_04 bus subsystem

VERILATOR ?= verilator
TOP       ?= tb_team_04
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIMARGS   ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -q "^Simulation completed successfully$$" $(LOG) || \
		(echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
